// File: common/pcx_pkg.sv
`default_nettype none

package pcx_pkg;

   ////////////////////
   // Sizing
   ////////////////////

   // Core sources feeding one bank
   localparam int num_src   = 4;
   localparam int src_id_w  = 2;
   // Packet width on the PCX bus
   localparam int pcx_width = 40;
   // Bank-side queue
   localparam int q_depth     = 8;
   localparam int q_ptr_w     = $clog2(q_depth);
   // Two packets in the pipe plus one grant in the same cycle
   localparam int q_stall_lvl = q_depth - 3;
   // Grant counters wrap at 255
   localparam int cnt_w     = 8;

   ////////////////////
   // Packet and control types
   ////////////////////

   // Request packet, 4+2+18+16 bits
   typedef struct packed {
      logic [3:0]  rqtype;
      logic [1:0]  cpu_id;
      logic [17:0] addr;
      logic [15:0] data;
   } pcx_pkt_t;

   // Control access, write sets the enable mask
   typedef struct packed {
      logic                wr;
      logic                rd;
      logic [src_id_w-1:0] idx;
      logic [num_src-1:0]  wdata;
   } csr_req_t;

   // Read response, valid one cycle after the read strobe
   typedef struct packed {
      logic             rvalid;
      logic [cnt_w-1:0] rdata;
   } csr_rsp_t;

endpackage

`default_nettype wire

// File: logic/pcx_src_buf.sv
`default_nettype none

module pcx_src_buf (
   input  wire logic              rclk,
   input  wire logic              rst_n,
   input  wire logic              req,
   input  wire pcx_pkg::pcx_pkt_t pkt,
   input  wire logic              grant,
   output logic                   has_req,
   output pcx_pkg::pcx_pkt_t      head,
   output logic                   full
);
   import pcx_pkg::*;

   // Two packet slots, no reset on payload
   pcx_pkt_t   mem [2];
   logic       wr_ptr;
   logic       rd_ptr;
   logic [1:0] count;
   logic       do_push;
   logic       do_pop;

   // Core never strobes into a full buffer
   assign do_push = req & ~full;
   // Arbiter only grants a source that shows a request
   assign do_pop  = grant & has_req;

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= 2'd0;
      end else begin
         if (do_push) wr_ptr <= ~wr_ptr;
         if (do_pop) rd_ptr <= ~rd_ptr;
         // Push and pop together leave the count alone
         count <= count + {1'b0, do_push} - {1'b0, do_pop};
      end
   end

   always_ff @(posedge rclk) begin
      if (do_push) mem[wr_ptr] <= pkt;
   end

   // Head packet straight to the arbiter mux
   assign head    = mem[rd_ptr];
   assign has_req = (count != 2'd0);
   assign full    = (count == 2'd2);

endmodule

`default_nettype wire

// File: logic/pcx_arb.sv
`default_nettype none

module pcx_arb (
   input  wire logic                                     rclk,
   input  wire logic                                     rst_n,
   input  wire logic [pcx_pkg::num_src-1:0]              has_req,
   input  wire pcx_pkg::pcx_pkt_t [pcx_pkg::num_src-1:0] heads,
   input  wire logic [pcx_pkg::num_src-1:0]              en_mask,
   input  wire logic                                     pcx_stall_pq_buf,
   output logic [pcx_pkg::num_src-1:0]                   grant,
   output logic [pcx_pkg::pcx_width-1:0]                 pcx_data_px_l,
   output logic                                          pcx_data_rdy_px
);
   import pcx_pkg::*;

   ////////////////////
   // Source select
   ////////////////////

   // Source with top priority this cycle
   logic [src_id_w-1:0] ptr;
   logic [src_id_w-1:0] sel;
   logic                found;
   logic [num_src-1:0]  elig;
   logic                take;

   // Masked sources keep their packets but are skipped
   assign elig = has_req & en_mask;

   // Walk from the pointer, first eligible source wins
   always_comb begin
      logic [src_id_w-1:0] cand;
      sel   = ptr;
      found = 1'b0;
      for (int i = 0; i < num_src; i++) begin
         cand = ptr + src_id_w'(i);
         if (!found && elig[cand]) begin
            sel   = cand;
            found = 1'b1;
         end
      end
   end

   // Nothing goes out while the queue asks for stall
   assign take = found & ~pcx_stall_pq_buf;

   always_comb begin
      grant = '0;
      if (take) grant[sel] = 1'b1;
   end

   // Next source after the winner gets top priority
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (take) begin
         ptr <= sel + 1'b1;
      end
   end

   ////////////////////
   // PCX bus register
   ////////////////////

   // Ready flag rides beside the data
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         pcx_data_rdy_px <= 1'b0;
      end else begin
         pcx_data_rdy_px <= take;
      end
   end

   // Bus is low-true across the long wire
   always_ff @(posedge rclk) begin
      if (take) pcx_data_px_l <= ~heads[sel];
   end

endmodule

`default_nettype wire

// File: logic/pcx_arb_csr.sv
`default_nettype none

module pcx_arb_csr (
   input  wire logic                        rclk,
   input  wire logic                        rst_n,
   input  wire pcx_pkg::csr_req_t           csr_req,
   input  wire logic [pcx_pkg::num_src-1:0] grant,
   output pcx_pkg::csr_rsp_t                csr_rsp,
   output logic [pcx_pkg::num_src-1:0]      en_mask
);
   import pcx_pkg::*;

   // One grant counter per source
   logic [cnt_w-1:0] cnt [num_src];

   ////////////////////
   // Enable mask
   ////////////////////

   // All sources enabled out of reset
   // Write index is ignored, the whole mask is one field
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         en_mask <= '1;
      end else if (csr_req.wr) begin
         en_mask <= csr_req.wdata;
      end
   end

   ////////////////////
   // Grant counters
   ////////////////////

   // Free-running, wrap past 255
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < num_src; i++) begin
            cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < num_src; i++) begin
            if (grant[i]) cnt[i] <= cnt[i] + 1'b1;
         end
      end
   end

   // Read data one cycle after the strobe
   // Count seen is the one before any grant in the read cycle
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         csr_rsp <= '0;
      end else begin
         csr_rsp.rvalid <= csr_req.rd;
         if (csr_req.rd) csr_rsp.rdata <= cnt[csr_req.idx];
      end
   end

endmodule

`default_nettype wire

// File: logic/pcx_data_px2.sv
`default_nettype none

module pcx_data_px2 (
   input  wire logic                          rclk,
   input  wire logic                          rst_n,
   input  wire logic [pcx_pkg::pcx_width-1:0] pcx_data_px_l,
   input  wire logic                          pcx_data_rdy_px,
   input  wire logic                          pcx_stall_pq,
   output pcx_pkg::pcx_pkt_t                  pcx_data_px2,
   output logic                               pcx_data_rdy_px2,
   output logic                               pcx_stall_pq_buf
);
   import pcx_pkg::*;

   // Still low-true after the retiming flop
   logic [pcx_width-1:0] pcx_data_px2_l;

   always_ff @(posedge rclk) begin
      pcx_data_px2_l <= pcx_data_px_l;
   end

   // Back to true polarity for the queue
   assign pcx_data_px2 = pcx_pkt_t'(~pcx_data_px2_l);

   // Ready follows its data by one stage
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) pcx_data_rdy_px2 <= 1'b0;
      else        pcx_data_rdy_px2 <= pcx_data_rdy_px;
   end

   // Stall heads upstream unregistered
   assign pcx_stall_pq_buf = pcx_stall_pq;

endmodule

`default_nettype wire

// File: logic/pcx_dest_queue.sv
`default_nettype none

module pcx_dest_queue (
   input  wire logic              rclk,
   input  wire logic              rst_n,
   input  wire logic              wr,
   input  wire pcx_pkg::pcx_pkt_t wr_pkt,
   input  wire logic              pop,
   output logic                   not_empty,
   output pcx_pkg::pcx_pkt_t      head,
   output logic                   stall
);
   import pcx_pkg::*;

   ////////////////////
   // Storage and pointers
   ////////////////////

   pcx_pkt_t           mem [q_depth];
   logic [q_ptr_w-1:0] wr_ptr;
   logic [q_ptr_w-1:0] rd_ptr;
   // One extra bit so a full queue reads as 8
   logic [q_ptr_w:0]   count;
   logic               q_full;
   logic               do_wr;
   logic               do_pop;

   assign q_full = (count == (q_ptr_w+1)'(q_depth));
   // Pop on an empty queue does nothing
   assign do_pop = pop & not_empty;
   // Stall level keeps this from ever dropping a packet
   assign do_wr  = wr & (~q_full | do_pop);

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap naturally at depth 8
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         count <= count + {{q_ptr_w{1'b0}}, do_wr} - {{q_ptr_w{1'b0}}, do_pop};
      end
   end

   always_ff @(posedge rclk) begin
      if (do_wr) mem[wr_ptr] <= wr_pkt;
   end

   ////////////////////
   // Bank side
   ////////////////////

   assign head      = mem[rd_ptr];
   assign not_empty = (count != '0);

   // Early stall covers the arbiter and retiming registers
   // plus a grant made on the edge that reaches the level
   assign stall = (count >= (q_ptr_w+1)'(q_stall_lvl));

endmodule

`default_nettype wire

// File: logic/pcx_xbar_slice.sv
`default_nettype none

module pcx_xbar_slice (
   input  wire logic                                     rclk,
   input  wire logic                                     rst_n,
   input  wire logic [pcx_pkg::num_src-1:0]              req,
   input  wire pcx_pkg::pcx_pkt_t [pcx_pkg::num_src-1:0] req_pkt,
   output logic [pcx_pkg::num_src-1:0]                   full,
   input  wire logic                                     pop,
   output logic                                          not_empty,
   output pcx_pkg::pcx_pkt_t                             head,
   output logic                                          stall,
   input  wire pcx_pkg::csr_req_t                        csr_req,
   output pcx_pkg::csr_rsp_t                             csr_rsp
);
   import pcx_pkg::*;

   // Buffer to arbiter
   logic [num_src-1:0]              has_req;
   pcx_pkt_t [num_src-1:0]          heads;
   logic [num_src-1:0]              grant;
   logic [num_src-1:0]              en_mask;
   // Arbiter to retiming stage, low-true data
   logic [pcx_width-1:0]            pcx_data_px_l;
   logic                            pcx_data_rdy_px;
   // Retiming stage to queue
   pcx_pkt_t                        pcx_data_px2;
   logic                            pcx_data_rdy_px2;
   logic                            pcx_stall_pq_buf;

   ////////////////////
   // Core-side buffers
   ////////////////////

   for (genvar g = 0; g < num_src; g++) begin : g_src
      pcx_src_buf u_src_buf (
         .rclk    (rclk),
         .rst_n   (rst_n),
         .req     (req[g]),
         .pkt     (req_pkt[g]),
         .grant   (grant[g]),
         .has_req (has_req[g]),
         .head    (heads[g]),
         .full    (full[g])
      );
   end

   ////////////////////
   // Arbitration and control
   ////////////////////

   pcx_arb u_arb (
      .rclk             (rclk),
      .rst_n            (rst_n),
      .has_req          (has_req),
      .heads            (heads),
      .en_mask          (en_mask),
      .pcx_stall_pq_buf (pcx_stall_pq_buf),
      .grant            (grant),
      .pcx_data_px_l    (pcx_data_px_l),
      .pcx_data_rdy_px  (pcx_data_rdy_px)
   );

   pcx_arb_csr u_arb_csr (
      .rclk    (rclk),
      .rst_n   (rst_n),
      .csr_req (csr_req),
      .grant   (grant),
      .csr_rsp (csr_rsp),
      .en_mask (en_mask)
   );

   ////////////////////
   // Retime and bank queue
   ////////////////////

   pcx_data_px2 u_data_px2 (
      .rclk             (rclk),
      .rst_n            (rst_n),
      .pcx_data_px_l    (pcx_data_px_l),
      .pcx_data_rdy_px  (pcx_data_rdy_px),
      .pcx_stall_pq     (stall),
      .pcx_data_px2     (pcx_data_px2),
      .pcx_data_rdy_px2 (pcx_data_rdy_px2),
      .pcx_stall_pq_buf (pcx_stall_pq_buf)
   );

   pcx_dest_queue u_dest_queue (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .wr        (pcx_data_rdy_px2),
      .wr_pkt    (pcx_data_px2),
      .pop       (pop),
      .not_empty (not_empty),
      .head      (head),
      .stall     (stall)
   );

endmodule

`default_nettype wire

// File: test/pcx_xbar_props.sv
`default_nettype none

module pcx_xbar_props (
   input wire logic                        rclk,
   input wire logic                        rst_n,
   input wire logic [pcx_pkg::num_src-1:0] req,
   input wire logic [pcx_pkg::num_src-1:0] full,
   input wire logic [pcx_pkg::num_src-1:0] grant,
   input wire logic                        stall,
   input wire logic                        pop,
   input wire logic                        not_empty,
   input wire logic                        pcx_data_rdy_px,
   input wire logic                        pcx_data_rdy_px2
);
   timeunit 1ns;
   timeprecision 1ps;
   import pcx_pkg::*;

   // Queue occupancy as seen from its write and pop sides
   int occ;

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) occ <= 0;
      else        occ <= occ + int'(pcx_data_rdy_px2) - int'(pop && not_empty);
   end

   ////////////////////
   // Handshake rules
   ////////////////////

   a_no_push_full : assert property (@(posedge rclk) disable iff (!rst_n)
      (req & full) == '0)
      else $error("Source strobed into a full buffer");

   a_one_grant : assert property (@(posedge rclk) disable iff (!rst_n) $onehot0(grant))
      else $error("More than one grant in a cycle");

   a_stall_hold : assert property (@(posedge rclk) disable iff (!rst_n)
      stall |-> grant == '0)
      else $error("Grant made while stall is high");

   // A write into a full queue only fits if the head leaves on the same edge
   a_q_room : assert property (@(posedge rclk) disable iff (!rst_n)
      pcx_data_rdy_px2 |-> (occ < q_depth) || (pop && not_empty))
      else $error("Queue written while full");

   a_rdy_reset : assert property (@(posedge rclk)
      !rst_n |-> !pcx_data_rdy_px && !pcx_data_rdy_px2)
      else $error("Ready flag high during reset");

endmodule

bind pcx_xbar_slice pcx_xbar_props u_props (
   .rclk             (rclk),
   .rst_n            (rst_n),
   .req              (req),
   .full             (full),
   .grant            (grant),
   .stall            (stall),
   .pop              (pop),
   .not_empty        (not_empty),
   .pcx_data_rdy_px  (pcx_data_rdy_px),
   .pcx_data_rdy_px2 (pcx_data_rdy_px2)
);

`default_nettype wire

// File: test/pcx_xbar_tb.sv
`default_nettype none

module pcx_xbar_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import pcx_pkg::*;

   // One row is one cycle of stimulus
   // Sync drains the slice before the row
   typedef struct packed {
      logic [3:0]  srcs;
      logic [3:0]  rqtype;
      logic [17:0] addr;
      logic [15:0] data;
      logic        pop_en;
      logic [3:0]  mask;
      logic        sync;
      logic        rr_chk;
      logic        chk_stall;
   } row_t;

   localparam int n_rows      = 21;
   localparam int cycle_limit = n_rows * 20;

   row_t rows [n_rows] = '{
      // All four from an idle slice with the rotation checked
      '{4'hf, 4'h1, 18'h00100, 16'h1111, 1'b1, 4'hf, 1'b1, 1'b1, 1'b0},
      '{4'hf, 4'h2, 18'h00200, 16'h2222, 1'b1, 4'hf, 1'b0, 1'b0, 1'b0},
      '{4'hf, 4'h3, 18'h00300, 16'h3333, 1'b1, 4'hf, 1'b0, 1'b0, 1'b0},
      '{4'h5, 4'h4, 18'h00400, 16'h4444, 1'b1, 4'hf, 1'b0, 1'b0, 1'b0},
      // Source 2 masked off while its packets wait in the buffer
      '{4'hf, 4'h5, 18'h10500, 16'h5555, 1'b1, 4'hb, 1'b1, 1'b0, 1'b0},
      '{4'h4, 4'h6, 18'h10600, 16'h6666, 1'b1, 4'hb, 1'b0, 1'b0, 1'b0},
      '{4'hb, 4'h7, 18'h10700, 16'h7777, 1'b1, 4'hb, 1'b0, 1'b0, 1'b0},
      '{4'hb, 4'h8, 18'h10800, 16'h8888, 1'b1, 4'hb, 1'b0, 1'b0, 1'b0},
      '{4'h0, 4'h0, 18'h00000, 16'h0000, 1'b1, 4'hf, 1'b0, 1'b0, 1'b0},
      // Pop held low until stall
      '{4'hf, 4'h9, 18'h20900, 16'h9999, 1'b0, 4'hf, 1'b1, 1'b0, 1'b0},
      '{4'hf, 4'ha, 18'h20a00, 16'haaaa, 1'b0, 4'hf, 1'b0, 1'b0, 1'b0},
      '{4'hf, 4'hb, 18'h20b00, 16'hbbbb, 1'b0, 4'hf, 1'b0, 1'b0, 1'b0},
      '{4'h0, 4'h0, 18'h00000, 16'h0000, 1'b0, 4'hf, 1'b0, 1'b0, 1'b0},
      '{4'h0, 4'h0, 18'h00000, 16'h0000, 1'b0, 4'hf, 1'b0, 1'b0, 1'b0},
      '{4'h0, 4'h0, 18'h00000, 16'h0000, 1'b0, 4'hf, 1'b0, 1'b0, 1'b0},
      '{4'h0, 4'h0, 18'h00000, 16'h0000, 1'b0, 4'hf, 1'b0, 1'b0, 1'b0},
      '{4'h0, 4'h0, 18'h00000, 16'h0000, 1'b0, 4'hf, 1'b0, 1'b0, 1'b0},
      '{4'h0, 4'h0, 18'h00000, 16'h0000, 1'b0, 4'hf, 1'b0, 1'b0, 1'b0},
      '{4'h0, 4'h0, 18'h00000, 16'h0000, 1'b0, 4'hf, 1'b0, 1'b0, 1'b1},
      // Popping resumes
      '{4'hf, 4'hc, 18'h30c00, 16'hcccc, 1'b1, 4'hf, 1'b0, 1'b0, 1'b0},
      '{4'h0, 4'h0, 18'h00000, 16'h0000, 1'b1, 4'hf, 1'b1, 1'b0, 1'b0}
   };

   logic                   rclk;
   logic                   rst_n;
   logic [num_src-1:0]     req;
   pcx_pkt_t [num_src-1:0] req_pkt;
   logic [num_src-1:0]     full;
   logic                   pop;
   logic                   not_empty;
   pcx_pkt_t               head;
   logic                   stall;
   csr_req_t               csr_req;
   csr_rsp_t               csr_rsp;

   // Scoreboard with one expected queue per source
   pcx_pkt_t   exp_q [num_src][$];
   int         deliv_cnt [num_src];
   int         pending;
   int         cycles;
   logic [3:0] cur_mask;
   logic [1:0] last_src;
   logic [1:0] rr_next;
   int         rr_left;

   pcx_xbar_slice UUT (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .req       (req),
      .req_pkt   (req_pkt),
      .full      (full),
      .pop       (pop),
      .not_empty (not_empty),
      .head      (head),
      .stall     (stall),
      .csr_req   (csr_req),
      .csr_rsp   (csr_rsp)
   );

   initial begin
      rclk = 1'b0;
      forever #20 rclk = ~rclk;
   end

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   // Strobe one packet per selected source
   // Cpu id names the source
   task automatic post_pkts(input logic [3:0] srcs, input logic [3:0] rqtype,
                            input logic [17:0] addr, input logic [15:0] data);
      pcx_pkt_t p;
      for (int s = 0; s < num_src; s++) begin
         if (srcs[s]) begin
            p.rqtype = rqtype;
            p.cpu_id = 2'(s);
            p.addr   = addr ^ 18'(s);
            p.data   = data ^ 16'($urandom);
            req[s]     = 1'b1;
            req_pkt[s] = p;
            exp_q[s].push_back(p);
            pending++;
         end
      end
   endtask

   // Packets of a masked source stay in its two-entry buffer
   task automatic check_masked_full();
      logic exp_full;
      for (int s = 0; s < num_src; s++) begin
         if (!cur_mask[s]) begin
            exp_full = (exp_q[s].size() >= 2);
            assert (full[s] == exp_full)
               else fail_run($sformatf("ERROR full[%0d]: got %h expected %h",
                                       s, full[s], exp_full));
         end
      end
   endtask

   task automatic drain();
      pop = 1'b1;
      while (pending != 0) begin
         @(posedge rclk);
         #2;
      end
   endtask

   task automatic read_cnt(input int idx);
      logic [7:0] exp;
      exp         = 8'(deliv_cnt[idx]);
      csr_req     = '0;
      csr_req.rd  = 1'b1;
      csr_req.idx = 2'(idx);
      @(posedge rclk);
      #2;
      csr_req = '0;
      assert (csr_rsp.rvalid) else fail_run("Read response missing one cycle after the read");
      assert (csr_rsp.rdata == exp)
         else fail_run($sformatf("ERROR csr_rsp.rdata: got %h expected %h", csr_rsp.rdata, exp));
   endtask

   ////////////////////
   // Delivery monitor
   ////////////////////

   always @(posedge rclk) begin
      pcx_pkt_t exp;
      int       s;
      cycles++;
      if (cycles >= cycle_limit) fail_run("Timeout, the run did not finish in time");
      if (rst_n && pop && not_empty) begin
         s = int'(head.cpu_id);
         assert (exp_q[s].size() > 0)
            else fail_run($sformatf("Unexpected packet delivered from source %0d", s));
         exp = exp_q[s].pop_front();
         assert (head == exp)
            else fail_run($sformatf("ERROR head: got %h expected %h", head, exp));
         assert (cur_mask[s]) else fail_run($sformatf("Masked source %0d was delivered", s));
         // Four packets posted together leave in rotation from the pointer
         if (rr_left > 0) begin
            assert (head.cpu_id == rr_next)
               else fail_run($sformatf("ERROR head.cpu_id: got %h expected %h",
                                       head.cpu_id, rr_next));
            rr_next = rr_next + 2'd1;
            rr_left--;
         end
         last_src = head.cpu_id;
         deliv_cnt[s]++;
         pending--;
      end
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial begin
      void'($urandom(29));
      rst_n    = 1'b1;
      req      = '0;
      req_pkt  = '0;
      pop      = 1'b0;
      csr_req  = '0;
      pending  = 0;
      cycles   = 0;
      cur_mask = 4'hf;
      last_src = 2'd3;
      rr_next  = 2'd0;
      rr_left  = 0;
      for (int i = 0; i < num_src; i++) deliv_cnt[i] = 0;
      #2 rst_n = 1'b0;
      repeat (3) @(posedge rclk);
      #2 rst_n = 1'b1;

      assert (!not_empty && !stall && !csr_rsp.rvalid)
         else fail_run("Queue, stall or read-valid not low after reset");

      // Lone packet shows up exactly three edges after its strobe
      post_pkts(4'h4, 4'h5, 18'h2abcd, 16'hbeef);
      for (int k = 0; k < 4; k++) begin
         @(posedge rclk);
         #2;
         req = '0;
         assert (not_empty == (k == 3))
            else fail_run($sformatf("ERROR not_empty: got %h expected %h after edge %0d",
                                    not_empty, k == 3, k));
      end
      assert (head == exp_q[2][0])
         else fail_run($sformatf("ERROR head: got %h expected %h", head, exp_q[2][0]));

      for (int i = 0; i < n_rows; i++) begin
         if (rows[i].sync) drain();
         pop = rows[i].pop_en;
         while ((rows[i].srcs & full) != '0) begin
            @(posedge rclk);
            #2;
         end
         if (rows[i].chk_stall) begin
            assert (stall) else fail_run("Stall did not rise with pop held low");
         end
         check_masked_full();
         if (rows[i].mask != cur_mask) begin
            csr_req.wr    = 1'b1;
            csr_req.wdata = rows[i].mask;
            cur_mask      = rows[i].mask;
         end
         if (rows[i].rr_chk) begin
            rr_next = last_src + 2'd1;
            rr_left = num_src;
         end
         post_pkts(rows[i].srcs, rows[i].rqtype, rows[i].addr, rows[i].data);
         @(posedge rclk);
         #2;
         req     = '0;
         csr_req = '0;
      end

      drain();
      @(posedge rclk);
      #2;
      assert (!not_empty) else fail_run("Queue still holds a packet after every packet arrived");
      // Counters read back the deliveries per source
      for (int i = 0; i < num_src; i++) read_cnt(i);

      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
common/pcx_pkg.sv
logic/pcx_src_buf.sv
logic/pcx_arb.sv
logic/pcx_arb_csr.sv
logic/pcx_data_px2.sv
logic/pcx_dest_queue.sv
logic/pcx_xbar_slice.sv
test/pcx_xbar_props.sv
test/pcx_xbar_tb.sv

// File: Makefile
TOP = pcx_xbar_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
